//--- mips_core.f
+incdir+rtl
+incdir+tb
rtl/mips_pkg.sv
rtl/mips_pipe_if.sv
rtl/mips_fetch.sv
rtl/mips_regfile.sv
rtl/mips_control.sv
rtl/mips_execute.sv
rtl/mips_mem_wb.sv
rtl/mips_core.sv
tb/tb_mips_core.sv

//--- tb/mips_iss.svh
`ifndef MIPS_ISS_SVH
`define MIPS_ISS_SVH

// one predicted register write
typedef struct packed {
	logic [`MIPS_XLEN-1:0]   pc;
	logic [`MIPS_REG_AW-1:0] num;
	logic [`MIPS_XLEN-1:0]   data;
} ret_t;

typedef struct packed {
	logic [`MIPS_XLEN-1:0] addr;
	logic [`MIPS_XLEN-1:0] data;
} store_t;

logic [`MIPS_XLEN-1:0] arch_regs [32];
logic [`MIPS_XLEN-1:0] arch_mem [256];
logic [`MIPS_XLEN-1:0] arch_pc;
logic [`MIPS_XLEN-1:0] arch_npc;
ret_t                  exp_ret_q [$];
store_t                exp_store_q [$];

// initial data memory contents, every address bit shows up in the word
function automatic logic [`MIPS_XLEN-1:0] fill_word(input int idx);
	logic [`MIPS_XLEN-1:0] a;
	a = 32'(idx) << 2;
	return 32'hd00d_0000 ^ a ^ (a << 20);
endfunction

task automatic reset_model();
	for (int i = 0; i < 32; i++) begin
		arch_regs[i] = '0;
	end
	for (int i = 0; i < 256; i++) begin
		arch_mem[i] = fill_word(i);
	end
	arch_pc = `MIPS_RESET_PC;
	arch_npc = `MIPS_RESET_PC + 32'd4;
	exp_ret_q.delete();
	exp_store_q.delete();
endtask

// executes one instruction, npc carries the delay slot
task automatic step_instr(output bit wrote, output ret_t r);
	logic [`MIPS_XLEN-1:0] w;
	logic [`MIPS_XLEN-1:0] a;
	logic [`MIPS_XLEN-1:0] b;
	logic [`MIPS_XLEN-1:0] simm;
	logic [`MIPS_XLEN-1:0] zimm;
	logic [`MIPS_XLEN-1:0] res;
	logic [`MIPS_XLEN-1:0] nxt;
	store_t                st;
	w = imem[arch_pc[8:2]];
	a = arch_regs[w[25:21]];
	b = arch_regs[w[20:16]];
	simm = {{16{w[15]}}, w[15:0]};
	zimm = {16'h0000, w[15:0]};
	nxt = arch_npc + 32'd4;
	res = '0;
	wrote = 1'b1;
	case (w[31:26])
		`OP_SPECIAL: begin
			case (w[5:0])
				`FN_ADDU: res = a + b;
				`FN_SUBU: res = a - b;
				`FN_AND:  res = a & b;
				`FN_OR:   res = a | b;
				`FN_XOR:  res = a ^ b;
				`FN_NOR:  res = ~(a | b);
				`FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				`FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
				default:  wrote = 1'b0;
			endcase
		end
		`OP_ADDIU: res = a + simm;
		`OP_SLTI:  res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
		`OP_ANDI:  res = a & zimm;
		`OP_ORI:   res = a | zimm;
		`OP_XORI:  res = a ^ zimm;
		`OP_LUI:   res = {w[15:0], 16'h0000};
		`OP_LW:    res = arch_mem[(a + simm) >> 2];
		`OP_SW: begin
			wrote = 1'b0;
			st.addr = a + simm;
			st.data = b;
			arch_mem[st.addr[9:2]] = b;
			exp_store_q.push_back(st);
		end
		`OP_BEQ: begin
			wrote = 1'b0;
			if (a == b)
				nxt = arch_npc + (simm << 2);
		end
		`OP_BNE: begin
			wrote = 1'b0;
			if (a != b)
				nxt = arch_npc + (simm << 2);
		end
		`OP_J: begin
			wrote = 1'b0;
			nxt = {arch_npc[31:28], w[25:0], 2'b00};
		end
		default: wrote = 1'b0;
	endcase
	r.pc = arch_pc;
	r.num = (w[31:26] == `OP_SPECIAL) ? w[15:11] : w[20:16];
	r.data = res;
	if (wrote && r.num != '0)
		arch_regs[r.num] = res;
	arch_pc = arch_npc;
	arch_npc = nxt;
endtask

// runs ahead to the next register write
task automatic advance_model();
	bit   wrote;
	ret_t r;
	int   n;
	wrote = 1'b0;
	n = 0;
	while (!wrote && n < 64) begin
		step_instr(wrote, r);
		n++;
	end
	if (wrote)
		exp_ret_q.push_back(r);
endtask

`endif

//--- tb/tb_mips_core.sv
`include "mips_defines.svh"

module tb_mips_core;

	logic                    clk;
	logic                    rst_i;
	logic [`MIPS_XLEN-1:0]   inst_data_i;
	logic [`MIPS_XLEN-1:0]   inst_addr_o;
	logic [`MIPS_XLEN-1:0]   ram_din_i;
	logic                    ram_en_o;
	logic                    ram_we_o;
	logic [`MIPS_XLEN-1:0]   ram_addr_o;
	logic [`MIPS_XLEN-1:0]   ram_dout_o;
	logic [`MIPS_XLEN-1:0]   debug_wb_pc_o;
	logic                    debug_wb_rf_wen_o;
	logic [`MIPS_REG_AW-1:0] debug_wb_rf_wnum_o;
	logic [`MIPS_XLEN-1:0]   debug_wb_rf_wdata_o;

	logic [`MIPS_XLEN-1:0] imem [128];
	logic [`MIPS_XLEN-1:0] dmem [256];
	logic [`MIPS_XLEN-1:0] seg_end [2:6];
	bit                    seg_done [2:6];
	int                    test_errs [1:6];
	int                    cur_test;
	int                    checks;
	int                    apc;
	integer                seed;
	bit                    stopped;

	`include "mips_iss.svh"

	mips_core dut0 (
		.clk                 (clk),
		.rst_i               (rst_i),
		.inst_data_i         (inst_data_i),
		.inst_addr_o         (inst_addr_o),
		.ram_din_i           (ram_din_i),
		.ram_en_o            (ram_en_o),
		.ram_we_o            (ram_we_o),
		.ram_addr_o          (ram_addr_o),
		.ram_dout_o          (ram_dout_o),
		.debug_wb_pc_o       (debug_wb_pc_o),
		.debug_wb_rf_wen_o   (debug_wb_rf_wen_o),
		.debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
		.debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
	);

	// program sits at the reset vector, low pc bits index the rom
	assign inst_data_i = imem[inst_addr_o[8:2]];
	assign ram_din_i = dmem[ram_addr_o[9:2]];

	always @(posedge clk) begin
		if (ram_we_o) begin
			dmem[ram_addr_o[9:2]] <= ram_dout_o;
		end
	end

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] r_word(input logic [5:0] fn, input logic [4:0] rd,
			input logic [4:0] rs, input logic [4:0] rt);
		return {`OP_SPECIAL, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] j_word(input logic [31:0] target);
		return {`OP_J, target[27:2]};
	endfunction

	function automatic logic [31:0] here();
		return `MIPS_RESET_PC + 32'(apc) * 32'd4;
	endfunction

	task automatic emit(input logic [31:0] w);
		imem[apc] = w;
		apc++;
	endtask

	task automatic load_const(input logic [4:0] rn, input logic [31:0] v);
		emit(i_word(`OP_LUI, rn, 5'd0, v[31:16]));
		emit(i_word(`OP_ORI, rn, rn, v[15:0]));
	endtask

	task automatic build_program();
		logic [31:0] rv [4];
		for (int i = 0; i < 128; i++) begin
			imem[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			dmem[i] = fill_word(i);
		end
		seed = 32'hecb7;
		for (int k = 0; k < 4; k++) begin
			rv[k] = $random(seed);
		end
		apc = 0;
		// dependent alu and immediate chain, one undefined opcode
		load_const(5'd1, rv[0]);
		load_const(5'd2, rv[1]);
		emit(r_word(`FN_ADDU, 5'd3, 5'd1, 5'd2));
		emit(r_word(`FN_SUBU, 5'd4, 5'd3, 5'd1));
		emit(r_word(`FN_AND, 5'd5, 5'd4, 5'd2));
		emit(r_word(`FN_OR, 5'd6, 5'd5, 5'd3));
		emit(r_word(`FN_XOR, 5'd7, 5'd6, 5'd4));
		emit(i_word(6'h3f, 5'd9, 5'd1, 16'h1234));
		emit(r_word(`FN_NOR, 5'd8, 5'd7, 5'd5));
		emit(r_word(`FN_SLT, 5'd9, 5'd8, 5'd1));
		emit(r_word(`FN_SLTU, 5'd10, 5'd1, 5'd8));
		emit(i_word(`OP_ADDIU, 5'd11, 5'd10, 16'hfffb));
		emit(i_word(`OP_ANDI, 5'd12, 5'd7, rv[2][15:0]));
		emit(i_word(`OP_XORI, 5'd13, 5'd12, rv[2][31:16]));
		emit(i_word(`OP_SLTI, 5'd14, 5'd13, rv[3][15:0]));
		seg_end[2] = here() - 32'd4;
		// loads consumed right away
		emit(i_word(`OP_ADDIU, 5'd20, 5'd0, 16'h0040));
		emit(i_word(`OP_LW, 5'd15, 5'd20, 16'h0000));
		emit(r_word(`FN_ADDU, 5'd16, 5'd15, 5'd1));
		emit(i_word(`OP_LW, 5'd17, 5'd20, 16'h0008));
		emit(i_word(`OP_LW, 5'd18, 5'd20, 16'h0004));
		emit(r_word(`FN_XOR, 5'd19, 5'd17, 5'd18));
		emit(r_word(`FN_OR, 5'd21, 5'd19, 5'd16));
		seg_end[3] = here() - 32'd4;
		// stores, then read back
		emit(i_word(`OP_SW, 5'd3, 5'd20, 16'h000c));
		emit(i_word(`OP_SW, 5'd7, 5'd20, 16'h0010));
		emit(i_word(`OP_ADDIU, 5'd22, 5'd20, 16'h0020));
		emit(i_word(`OP_SW, 5'd22, 5'd22, 16'h0000));
		emit(i_word(`OP_LW, 5'd23, 5'd20, 16'h000c));
		emit(i_word(`OP_LW, 5'd24, 5'd22, 16'h0000));
		emit(r_word(`FN_SUBU, 5'd25, 5'd24, 5'd23));
		seg_end[4] = here() - 32'd4;
		// branch offset 2 skips the word after the delay slot
		emit(i_word(`OP_BEQ, 5'd1, 5'd1, 16'd2));
		emit(i_word(`OP_ADDIU, 5'd26, 5'd0, 16'd1));
		emit(i_word(`OP_ADDIU, 5'd26, 5'd26, 16'd100));
		emit(i_word(`OP_ADDIU, 5'd27, 5'd26, 16'd2));
		emit(i_word(`OP_ADDIU, 5'd28, 5'd0, 16'd5));
		emit(i_word(`OP_BNE, 5'd0, 5'd28, 16'd2));
		emit(i_word(`OP_ADDIU, 5'd29, 5'd28, 16'd3));
		emit(i_word(`OP_ADDIU, 5'd29, 5'd0, 16'h0077));
		emit(i_word(`OP_BEQ, 5'd0, 5'd28, 16'd2));
		emit(i_word(`OP_ORI, 5'd29, 5'd29, 16'h0010));
		emit(i_word(`OP_BNE, 5'd26, 5'd26, 16'd2));
		emit(r_word(`FN_ADDU, 5'd27, 5'd27, 5'd29));
		emit(i_word(`OP_LW, 5'd30, 5'd20, 16'h0000));
		emit(i_word(`OP_BEQ, 5'd15, 5'd30, 16'd2));
		emit(r_word(`FN_XOR, 5'd30, 5'd30, 5'd27));
		emit(i_word(`OP_ADDIU, 5'd30, 5'd0, 16'd1));
		emit(j_word(here() + 32'd12));
		emit(i_word(`OP_ADDIU, 5'd28, 5'd28, 16'd7));
		emit(i_word(`OP_ADDIU, 5'd28, 5'd0, 16'd0));
		emit(i_word(`OP_XORI, 5'd27, 5'd28, 16'h5a5a));
		seg_end[5] = here() - 32'd4;
		// end marker, then spin with a nop delay slot
		emit(i_word(`OP_ADDIU, 5'd31, 5'd0, 16'h07ff));
		seg_end[6] = here() - 32'd4;
		emit(j_word(here()));
		emit(32'h0000_0000);
	endtask

	function automatic string test_name(input int t);
		case (t)
			1: return "reset state";
			2: return "dependent alu chain";
			3: return "load use";
			4: return "stores";
			5: return "branches and jumps";
			default: return "program completion";
		endcase
	endfunction

	task automatic report_mismatch(input int t, input string sig, input logic [31:0] exp,
			input logic [31:0] got);
		$display("Mismatch at %0t: %s expected %h got %h", $time, sig, exp, got);
		test_errs[t]++;
	endtask

	task automatic check_retire();
		ret_t e;
		int   tries;
		tries = 0;
		while (exp_ret_q.size() == 0 && tries < 4) begin
			advance_model();
			tries++;
		end
		if (exp_ret_q.size() == 0) begin
			$display("core wrote a register at pc %h but the model expects no more writes",
				debug_wb_pc_o);
			test_errs[cur_test]++;
		end else begin
			e = exp_ret_q.pop_front();
			checks += 3;
			ret_pc: assert (debug_wb_pc_o == e.pc)
				else report_mismatch(cur_test, "debug_wb_pc_o", e.pc, debug_wb_pc_o);
			ret_num: assert (debug_wb_rf_wnum_o == e.num)
				else report_mismatch(cur_test, "debug_wb_rf_wnum_o", 32'(e.num),
					32'(debug_wb_rf_wnum_o));
			ret_data: assert (debug_wb_rf_wdata_o == e.data)
				else report_mismatch(cur_test, "debug_wb_rf_wdata_o", e.data,
					debug_wb_rf_wdata_o);
		end
		for (int k = 2; k <= 6; k++) begin
			if (debug_wb_pc_o == seg_end[k])
				seg_done[k] = 1'b1;
		end
	endtask

	task automatic check_store();
		store_t s;
		int     tries;
		tries = 0;
		while (exp_store_q.size() == 0 && tries < 8) begin
			advance_model();
			tries++;
		end
		if (exp_store_q.size() == 0) begin
			$display("core stored to %h but the model expects no more stores", ram_addr_o);
			test_errs[4]++;
		end else begin
			s = exp_store_q.pop_front();
			checks += 2;
			st_addr: assert (ram_addr_o == s.addr)
				else report_mismatch(4, "ram_addr_o", s.addr, ram_addr_o);
			st_data: assert (ram_dout_o == s.data)
				else report_mismatch(4, "ram_dout_o", s.data, ram_dout_o);
		end
	endtask

	// outputs are settled by the falling edge
	always @(negedge clk) begin
		if (!rst_i) begin
			if (debug_wb_rf_wen_o)
				check_retire();
			if (ram_we_o)
				check_store();
		end
	end

	task automatic wait_segment(input int k);
		int cnt;
		cnt = 0;
		while (!seg_done[k] && cnt < 400) begin
			@(posedge clk);
			cnt++;
		end
		if (!seg_done[k]) begin
			$display("core stopped retiring: pc %h not reached within %0d cycles",
				seg_end[k], cnt);
			test_errs[k]++;
			stopped = 1'b1;
		end
	endtask

	task automatic finish_test(input int t);
		if (test_errs[t] == 0)
			$display("test %0d %s: passed", t, test_name(t));
		else
			$display("test %0d %s: failed with %0d errors", t, test_name(t), test_errs[t]);
	endtask

	initial begin
		int total;
		int passed;
		int run;
		rst_i = 1'b1;
		checks = 0;
		stopped = 1'b0;
		cur_test = 1;
		for (int t = 1; t <= 6; t++) begin
			test_errs[t] = 0;
		end
		for (int k = 2; k <= 6; k++) begin
			seg_done[k] = 1'b0;
		end
		build_program();
		reset_model();
		repeat (8) @(posedge clk);
		rst_i <= 1'b0;
		@(negedge clk);
		checks += 4;
		rst_en: assert (ram_en_o == 1'b0)
			else report_mismatch(1, "ram_en_o", 32'd0, 32'(ram_en_o));
		rst_we: assert (ram_we_o == 1'b0)
			else report_mismatch(1, "ram_we_o", 32'd0, 32'(ram_we_o));
		rst_wen: assert (debug_wb_rf_wen_o == 1'b0)
			else report_mismatch(1, "debug_wb_rf_wen_o", 32'd0, 32'(debug_wb_rf_wen_o));
		rst_pc: assert (inst_addr_o == `MIPS_RESET_PC)
			else report_mismatch(1, "inst_addr_o", `MIPS_RESET_PC, inst_addr_o);
		finish_test(1);
		run = 1;
		for (int t = 2; t <= 6; t++) begin
			if (!stopped) begin
				cur_test = t;
				wait_segment(t);
				finish_test(t);
				run++;
			end
		end
		total = 0;
		passed = 0;
		for (int t = 1; t <= 6; t++) begin
			total += test_errs[t];
			if (test_errs[t] == 0 && t <= run)
				passed++;
		end
		$display("summary: %0d of 6 tests run, %0d passed, %0d checks, %0d errors",
			run, passed, checks, total);
		if (total == 0 && !stopped) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- rtl/mips_core.sv
`include "mips_defines.svh"

module mips_core (
	input  logic                    clk,
	input  logic                    rst_i,
	input  logic [`MIPS_XLEN-1:0]   inst_data_i,
	output logic [`MIPS_XLEN-1:0]   inst_addr_o,
	input  logic [`MIPS_XLEN-1:0]   ram_din_i,
	output logic                    ram_en_o,
	output logic                    ram_we_o,
	output logic [`MIPS_XLEN-1:0]   ram_addr_o,
	output logic [`MIPS_XLEN-1:0]   ram_dout_o,
	output logic [`MIPS_XLEN-1:0]   debug_wb_pc_o,
	output logic                    debug_wb_rf_wen_o,
	output logic [`MIPS_REG_AW-1:0] debug_wb_rf_wnum_o,
	output logic [`MIPS_XLEN-1:0]   debug_wb_rf_wdata_o
);

	mips_pkg::instr_u        id_instr;
	mips_pkg::id_ctrl_t      id_ctrl;
	mips_pkg::id_ctrl_t      ex_ctrl;
	logic [`MIPS_XLEN-1:0]   id_pc;
	logic [`MIPS_XLEN-1:0]   id_imm;
	logic [`MIPS_XLEN-1:0]   id_opa;
	logic [`MIPS_XLEN-1:0]   rda;
	logic [`MIPS_XLEN-1:0]   rdb;
	logic [`MIPS_XLEN-1:0]   target;
	logic [`MIPS_XLEN-1:0]   ex_result;
	logic [`MIPS_XLEN-1:0]   ex_store_data;
	logic [`MIPS_XLEN-1:0]   wb_data;
	logic [`MIPS_REG_AW-1:0] wb_dst;
	logic                    wb_we;
	logic                    stall;
	logic                    redirect;

	mips_pipe_if m_pipe ();

	mips_fetch m_fetch (
		.clk         (clk),
		.rst_i       (rst_i),
		.stall_i     (stall),
		.redirect_i  (redirect),
		.target_i    (target),
		.inst_data_i (inst_data_i),
		.pc_o        (inst_addr_o),
		.id_instr_o  (id_instr),
		.id_pc_o     (id_pc)
	);

	mips_regfile m_regfile (
		.clk   (clk),
		.rst_i (rst_i),
		.ra_i  (id_instr.r.rs),
		.rb_i  (id_instr.r.rt),
		.wa_i  (wb_dst),
		.we_i  (wb_we),
		.wd_i  (wb_data),
		.rda_o (rda),
		.rdb_o (rdb)
	);

	mips_control m_control (
		.instr_i    (id_instr),
		.pc_i       (id_pc),
		.rda_i      (rda),
		.rdb_i      (rdb),
		.pipe       (m_pipe.ctrl),
		.ctrl_o     (id_ctrl),
		.imm_o      (id_imm),
		.opa_o      (id_opa),
		.stall_o    (stall),
		.redirect_o (redirect),
		.target_o   (target)
	);

	mips_execute m_execute (
		.clk             (clk),
		.rst_i           (rst_i),
		.stall_i         (stall),
		.ctrl_i          (id_ctrl),
		.rs_i            (id_instr.i.rs),
		.rt_i            (id_instr.i.rt),
		.imm_i           (id_imm),
		.rda_i           (id_opa),
		.rdb_i           (rdb),
		.pipe            (m_pipe.ex),
		.ex_ctrl_o       (ex_ctrl),
		.ex_store_data_o (ex_store_data),
		.ex_result_o     (ex_result)
	);

	mips_mem_wb m_mem_wb (
		.clk          (clk),
		.rst_i        (rst_i),
		.ctrl_i       (ex_ctrl),
		.result_i     (ex_result),
		.store_data_i (ex_store_data),
		.pc_i         (id_pc),
		.ram_din_i    (ram_din_i),
		.pipe         (m_pipe.mw),
		.ram_en_o     (ram_en_o),
		.ram_we_o     (ram_we_o),
		.ram_addr_o   (ram_addr_o),
		.ram_dout_o   (ram_dout_o),
		.wb_we_o      (wb_we),
		.wb_dst_o     (wb_dst),
		.wb_data_o    (wb_data),
		.wb_pc_o      (debug_wb_pc_o)
	);

	assign debug_wb_rf_wen_o = wb_we;
	assign debug_wb_rf_wnum_o = wb_dst;
	assign debug_wb_rf_wdata_o = wb_data;

endmodule

//--- rtl/mips_mem_wb.sv
`include "mips_defines.svh"

module mips_mem_wb (
	input  logic                    clk,
	input  logic                    rst_i,
	input  mips_pkg::id_ctrl_t      ctrl_i,
	input  logic [`MIPS_XLEN-1:0]   result_i,
	input  logic [`MIPS_XLEN-1:0]   store_data_i,
	input  logic [`MIPS_XLEN-1:0]   pc_i,
	input  logic [`MIPS_XLEN-1:0]   ram_din_i,
	mips_pipe_if.mw                 pipe,
	output logic                    ram_en_o,
	output logic                    ram_we_o,
	output logic [`MIPS_XLEN-1:0]   ram_addr_o,
	output logic [`MIPS_XLEN-1:0]   ram_dout_o,
	output logic                    wb_we_o,
	output logic [`MIPS_REG_AW-1:0] wb_dst_o,
	output logic [`MIPS_XLEN-1:0]   wb_data_o,
	output logic [`MIPS_XLEN-1:0]   wb_pc_o
);

	mips_pkg::id_ctrl_t    mem_ctrl;
	logic [`MIPS_XLEN-1:0] ex_pc;
	logic [`MIPS_XLEN-1:0] mem_result;
	logic [`MIPS_XLEN-1:0] mem_sdata;
	logic [`MIPS_XLEN-1:0] mem_pc;
	logic                  wb_wreg;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			mem_ctrl <= '0;
			wb_wreg <= 1'b0;
		end else begin
			mem_ctrl <= ctrl_i;
			wb_wreg <= mem_ctrl.wreg;
		end
	end

	// decode pc trails into execute here, bubbles never retire
	always_ff @(posedge clk) begin
		ex_pc <= pc_i;
		mem_pc <= ex_pc;
		mem_result <= result_i;
		mem_sdata <= store_data_i;
		wb_pc_o <= mem_pc;
		wb_dst_o <= mem_ctrl.dst;
		wb_data_o <= mem_ctrl.is_load ? ram_din_i : mem_result;
	end

	assign ram_en_o = mem_ctrl.is_load || mem_ctrl.is_store;
	assign ram_we_o = mem_ctrl.is_store;
	assign ram_addr_o = mem_result;
	assign ram_dout_o = mem_sdata;
	assign wb_we_o = wb_wreg;

	assign pipe.mem_dst = mem_ctrl.dst;
	assign pipe.mem_wreg = mem_ctrl.wreg;
	assign pipe.mem_load = mem_ctrl.is_load;
	assign pipe.mem_result = mem_result;
	assign pipe.wb_dst = wb_dst_o;
	assign pipe.wb_wreg = wb_wreg;
	assign pipe.wb_result = wb_data_o;

	// a store never claims a register on its way out
	store_strobe: assert property (@(posedge clk) disable iff (rst_i)
		ram_we_o |-> ram_en_o && !mem_ctrl.wreg ##1 !wb_wreg)
		else $error("store write strobe without enable or with a register write");

endmodule

//--- rtl/mips_execute.sv
`include "mips_defines.svh"

module mips_execute (
	input  logic                    clk,
	input  logic                    rst_i,
	input  logic                    stall_i,
	input  mips_pkg::id_ctrl_t      ctrl_i,
	input  logic [`MIPS_REG_AW-1:0] rs_i,
	input  logic [`MIPS_REG_AW-1:0] rt_i,
	input  logic [`MIPS_XLEN-1:0]   imm_i,
	input  logic [`MIPS_XLEN-1:0]   rda_i,
	input  logic [`MIPS_XLEN-1:0]   rdb_i,
	mips_pipe_if.ex                 pipe,
	output mips_pkg::id_ctrl_t      ex_ctrl_o,
	output logic [`MIPS_XLEN-1:0]   ex_store_data_o,
	output logic [`MIPS_XLEN-1:0]   ex_result_o
);

	mips_pkg::fw_sel_e       fw_a_q;
	mips_pkg::fw_sel_e       fw_b_q;
	logic [`MIPS_REG_AW-1:0] rs_q;
	logic [`MIPS_REG_AW-1:0] rt_q;
	logic [`MIPS_XLEN-1:0]   imm_q;
	logic [`MIPS_XLEN-1:0]   rda_q;
	logic [`MIPS_XLEN-1:0]   rdb_q;
	logic [`MIPS_XLEN-1:0]   opa;
	logic [`MIPS_XLEN-1:0]   opb;
	logic [`MIPS_XLEN-1:0]   src_b;

	// bubble on stall: nothing written, nothing stored
	always_ff @(posedge clk) begin
		if (rst_i || stall_i) begin
			ex_ctrl_o <= '0;
			fw_a_q <= mips_pkg::FW_RF;
			fw_b_q <= mips_pkg::FW_RF;
		end else begin
			ex_ctrl_o <= ctrl_i;
			fw_a_q <= pipe.fw_a;
			fw_b_q <= pipe.fw_b;
		end
	end

	always_ff @(posedge clk) begin
		rs_q <= rs_i;
		rt_q <= rt_i;
		imm_q <= imm_i;
		rda_q <= rda_i;
		rdb_q <= rdb_i;
	end

	always_comb begin
		case (fw_a_q)
			mips_pkg::FW_MEM: opa = pipe.mem_result;
			mips_pkg::FW_WB:  opa = pipe.wb_result;
			default:          opa = rda_q;
		endcase
		case (fw_b_q)
			mips_pkg::FW_MEM: opb = pipe.mem_result;
			mips_pkg::FW_WB:  opb = pipe.wb_result;
			default:          opb = rdb_q;
		endcase
	end

	assign src_b = ex_ctrl_o.use_imm ? imm_q : opb;

	// also the load/store address
	always_comb begin
		case (ex_ctrl_o.alu_op)
			mips_pkg::ALU_SUB:   ex_result_o = opa - src_b;
			mips_pkg::ALU_AND:   ex_result_o = opa & src_b;
			mips_pkg::ALU_OR:    ex_result_o = opa | src_b;
			mips_pkg::ALU_XOR:   ex_result_o = opa ^ src_b;
			mips_pkg::ALU_NOR:   ex_result_o = ~(opa | src_b);
			mips_pkg::ALU_SLT:   ex_result_o = `MIPS_XLEN'($signed(opa) < $signed(src_b));
			mips_pkg::ALU_SLTU:  ex_result_o = `MIPS_XLEN'(opa < src_b);
			mips_pkg::ALU_PASSB: ex_result_o = src_b;
			default:             ex_result_o = opa + src_b;
		endcase
	end

	assign ex_store_data_o = opb;

	assign pipe.ex_dst = ex_ctrl_o.dst;
	assign pipe.ex_wreg = ex_ctrl_o.wreg;
	assign pipe.ex_load = ex_ctrl_o.is_load;
	assign pipe.ex_result = ex_result_o;

	// a select picked in decode must still name the stage holding that register
	fw_a_stage: assert property (@(posedge clk) disable iff (rst_i)
		(fw_a_q != mips_pkg::FW_RF) |->
		((fw_a_q == mips_pkg::FW_MEM) ? pipe.mem_dst : pipe.wb_dst) == rs_q)
		else $error("rs forward source lost its producer");
	fw_b_stage: assert property (@(posedge clk) disable iff (rst_i)
		(fw_b_q != mips_pkg::FW_RF) |->
		((fw_b_q == mips_pkg::FW_MEM) ? pipe.mem_dst : pipe.wb_dst) == rt_q)
		else $error("rt forward source lost its producer");

endmodule

//--- rtl/mips_control.sv
`include "mips_defines.svh"

module mips_control (
	input  mips_pkg::instr_u      instr_i,
	input  logic [`MIPS_XLEN-1:0] pc_i,
	input  logic [`MIPS_XLEN-1:0] rda_i,
	input  logic [`MIPS_XLEN-1:0] rdb_i,
	mips_pipe_if.ctrl             pipe,
	output mips_pkg::id_ctrl_t    ctrl_o,
	output logic [`MIPS_XLEN-1:0] imm_o,
	output logic [`MIPS_XLEN-1:0] opa_o,
	output logic                  stall_o,
	output logic                  redirect_o,
	output logic [`MIPS_XLEN-1:0] target_o
);

	logic [`MIPS_REG_AW-1:0] rs;
	logic [`MIPS_REG_AW-1:0] rt;
	logic                    is_beq;
	logic                    is_bne;
	logic                    is_j;
	logic [`MIPS_XLEN-1:0]   id_a;
	logic [`MIPS_XLEN-1:0]   id_b;
	logic [`MIPS_XLEN-1:0]   pc4;
	logic                    taken;
	logic                    load_use;
	logic                    br_hazard;

	function automatic logic hit(input logic wreg, input logic [`MIPS_REG_AW-1:0] dst,
			input logic [`MIPS_REG_AW-1:0] rn);
		return wreg && (dst != '0) && (dst == rn);
	endfunction

	assign rs = instr_i.i.rs;
	assign rt = instr_i.i.rt;

	always_comb begin
		ctrl_o = '0;
		ctrl_o.alu_op = mips_pkg::ALU_ADD;
		ctrl_o.use_imm = 1'b1;
		ctrl_o.dst = instr_i.i.rt;
		is_beq = 1'b0;
		is_bne = 1'b0;
		is_j = 1'b0;
		case (instr_i.r.op)
			`OP_SPECIAL: begin
				ctrl_o.use_imm = 1'b0;
				ctrl_o.dst = instr_i.r.rd;
				ctrl_o.wreg = 1'b1;
				case (instr_i.r.funct)
					`FN_ADDU: ctrl_o.alu_op = mips_pkg::ALU_ADD;
					`FN_SUBU: ctrl_o.alu_op = mips_pkg::ALU_SUB;
					`FN_AND:  ctrl_o.alu_op = mips_pkg::ALU_AND;
					`FN_OR:   ctrl_o.alu_op = mips_pkg::ALU_OR;
					`FN_XOR:  ctrl_o.alu_op = mips_pkg::ALU_XOR;
					`FN_NOR:  ctrl_o.alu_op = mips_pkg::ALU_NOR;
					`FN_SLT:  ctrl_o.alu_op = mips_pkg::ALU_SLT;
					`FN_SLTU: ctrl_o.alu_op = mips_pkg::ALU_SLTU;
					default:  ctrl_o.wreg = 1'b0;
				endcase
			end
			`OP_ADDIU: ctrl_o.wreg = 1'b1;
			`OP_SLTI: begin
				ctrl_o.wreg = 1'b1;
				ctrl_o.alu_op = mips_pkg::ALU_SLT;
			end
			`OP_ANDI, `OP_ORI, `OP_XORI: begin
				ctrl_o.wreg = 1'b1;
				ctrl_o.zero_ext = 1'b1;
				ctrl_o.alu_op = (instr_i.i.op == `OP_ANDI) ? mips_pkg::ALU_AND :
					(instr_i.i.op == `OP_ORI) ? mips_pkg::ALU_OR : mips_pkg::ALU_XOR;
			end
			`OP_LUI: begin
				ctrl_o.wreg = 1'b1;
				ctrl_o.alu_op = mips_pkg::ALU_PASSB;
			end
			`OP_LW: begin
				ctrl_o.wreg = 1'b1;
				ctrl_o.is_load = 1'b1;
			end
			`OP_SW:  ctrl_o.is_store = 1'b1;
			`OP_BEQ: is_beq = 1'b1;
			`OP_BNE: is_bne = 1'b1;
			`OP_J:   is_j = 1'b1;
			default: ctrl_o.wreg = 1'b0;
		endcase
	end

	always_comb begin
		if (instr_i.i.op == `OP_LUI)
			imm_o = {instr_i.i.imm, 16'h0000};
		else if (ctrl_o.zero_ext)
			imm_o = {16'h0000, instr_i.i.imm};
		else
			imm_o = {{16{instr_i.i.imm[15]}}, instr_i.i.imm};
	end

	// decode operands for the branch compare, mem before wb
	assign id_a = hit(pipe.mem_wreg, pipe.mem_dst, rs) ? pipe.mem_result :
		hit(pipe.wb_wreg, pipe.wb_dst, rs) ? pipe.wb_result : rda_i;
	assign id_b = hit(pipe.mem_wreg, pipe.mem_dst, rt) ? pipe.mem_result :
		hit(pipe.wb_wreg, pipe.wb_dst, rt) ? pipe.wb_result : rdb_i;

	// an execute-stage producer is picked up by fw_a instead
	assign opa_o = id_a;

	// selects are for the cycle this instruction spends in execute
	assign pipe.fw_a = hit(pipe.ex_wreg, pipe.ex_dst, rs) ? mips_pkg::FW_MEM :
		hit(pipe.mem_wreg, pipe.mem_dst, rs) ? mips_pkg::FW_WB : mips_pkg::FW_RF;
	assign pipe.fw_b = hit(pipe.ex_wreg, pipe.ex_dst, rt) ? mips_pkg::FW_MEM :
		hit(pipe.mem_wreg, pipe.mem_dst, rt) ? mips_pkg::FW_WB : mips_pkg::FW_RF;

	// j carries no register operands
	assign load_use = pipe.ex_load && !is_j &&
		(hit(pipe.ex_wreg, pipe.ex_dst, rs) || hit(pipe.ex_wreg, pipe.ex_dst, rt));
	assign br_hazard = (is_beq || is_bne) &&
		(hit(pipe.ex_wreg, pipe.ex_dst, rs) || hit(pipe.ex_wreg, pipe.ex_dst, rt) ||
		(pipe.mem_load &&
		(hit(pipe.mem_wreg, pipe.mem_dst, rs) || hit(pipe.mem_wreg, pipe.mem_dst, rt))));
	assign stall_o = load_use || br_hazard;

	assign pc4 = pc_i + `MIPS_XLEN'(4);
	assign taken = is_j || (is_beq && id_a == id_b) || (is_bne && id_a != id_b);
	// a branch load-use case is already inside br_hazard
	assign redirect_o = taken && !br_hazard;
	assign target_o = is_j ? {pc4[31:28], instr_i.j.target, 2'b00} :
		pc4 + {{14{instr_i.i.imm[15]}}, instr_i.i.imm, 2'b00};

	always_comb begin
		assert final (!(redirect_o && stall_o))
			else $error("branch redirect raised while decode is stalled");
	end

endmodule

//--- rtl/mips_regfile.sv
`include "mips_defines.svh"

module mips_regfile (
	input  logic                    clk,
	input  logic                    rst_i,
	input  logic [`MIPS_REG_AW-1:0] ra_i,
	input  logic [`MIPS_REG_AW-1:0] rb_i,
	input  logic [`MIPS_REG_AW-1:0] wa_i,
	input  logic                    we_i,
	input  logic [`MIPS_XLEN-1:0]   wd_i,
	output logic [`MIPS_XLEN-1:0]   rda_o,
	output logic [`MIPS_XLEN-1:0]   rdb_o
);

	logic [`MIPS_XLEN-1:0] regs [2**`MIPS_REG_AW];
	logic                  wr_live;

	assign wr_live = we_i && (wa_i != '0);

	// r0 is cleared on reset and never written after
	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < 2**`MIPS_REG_AW; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_live) begin
			regs[wa_i] <= wd_i;
		end
	end

	// write-through so decode sees this cycle's retirement
	assign rda_o = (wr_live && wa_i == ra_i) ? wd_i : regs[ra_i];
	assign rdb_o = (wr_live && wa_i == rb_i) ? wd_i : regs[rb_i];

endmodule

//--- rtl/mips_fetch.sv
`include "mips_defines.svh"

module mips_fetch (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic                  stall_i,
	input  logic                  redirect_i,
	input  logic [`MIPS_XLEN-1:0] target_i,
	input  logic [`MIPS_XLEN-1:0] inst_data_i,
	output logic [`MIPS_XLEN-1:0] pc_o,
	output mips_pkg::instr_u      id_instr_o,
	output logic [`MIPS_XLEN-1:0] id_pc_o
);

	logic [`MIPS_XLEN-1:0] pc_q;

	// redirect arrives while the delay slot is being fetched
	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc_q <= `MIPS_RESET_PC;
		end else if (!stall_i) begin
			pc_q <= redirect_i ? target_i : pc_q + `MIPS_XLEN'(4);
		end
	end

	// all-zero word decodes as a no-op
	always_ff @(posedge clk) begin
		if (rst_i) begin
			id_instr_o <= '0;
		end else if (!stall_i) begin
			id_instr_o <= inst_data_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i) begin
			id_pc_o <= pc_q;
		end
	end

	assign pc_o = pc_q;

	pc_aligned: assert property (@(posedge clk) disable iff (rst_i) pc_q[1:0] == 2'b00)
		else $error("fetch pc %h not word aligned", pc_q);

endmodule

//--- rtl/mips_pipe_if.sv
`include "mips_defines.svh"

interface mips_pipe_if;

	// execute stage
	logic [`MIPS_REG_AW-1:0] ex_dst;
	logic                    ex_wreg;
	logic                    ex_load;
	logic [`MIPS_XLEN-1:0]   ex_result;

	// memory and write-back stages
	logic [`MIPS_REG_AW-1:0] mem_dst;
	logic                    mem_wreg;
	logic                    mem_load;
	logic [`MIPS_XLEN-1:0]   mem_result;
	logic [`MIPS_REG_AW-1:0] wb_dst;
	logic                    wb_wreg;
	logic [`MIPS_XLEN-1:0]   wb_result;

	// operand sources for the instruction leaving decode
	mips_pkg::fw_sel_e fw_a;
	mips_pkg::fw_sel_e fw_b;

	modport ex (
		output ex_dst, ex_wreg, ex_load, ex_result,
		input  fw_a, fw_b, mem_dst, mem_wreg, mem_result, wb_dst, wb_wreg, wb_result
	);

	modport mw (
		output mem_dst, mem_wreg, mem_load, mem_result, wb_dst, wb_wreg, wb_result
	);

	modport ctrl (
		output fw_a, fw_b,
		input  ex_dst, ex_wreg, ex_load, ex_result,
		input  mem_dst, mem_wreg, mem_load, mem_result, wb_dst, wb_wreg, wb_result
	);

endinterface

//--- rtl/mips_pkg.sv
`include "mips_defines.svh"

package mips_pkg;

	typedef struct packed {
		logic [5:0]              op;
		logic [`MIPS_REG_AW-1:0] rs;
		logic [`MIPS_REG_AW-1:0] rt;
		logic [`MIPS_REG_AW-1:0] rd;
		logic [4:0]              shamt;
		logic [5:0]              funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]              op;
		logic [`MIPS_REG_AW-1:0] rs;
		logic [`MIPS_REG_AW-1:0] rt;
		logic [15:0]             imm;
	} i_fmt_t;

	typedef struct packed {
		logic [5:0]  op;
		logic [25:0] target;
	} j_fmt_t;

	// one fetched word, seen through each encoding
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} instr_u;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_PASSB
	} alu_op_e;

	typedef enum logic [1:0] {
		FW_RF  = 2'd0,
		FW_MEM = 2'd1,
		FW_WB  = 2'd2
	} fw_sel_e;

	typedef struct packed {
		alu_op_e                 alu_op;
		logic                    use_imm;
		logic                    zero_ext;
		logic                    wreg;
		logic                    is_load;
		logic                    is_store;
		logic [`MIPS_REG_AW-1:0] dst;
	} id_ctrl_t;

endpackage

//--- rtl/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

`define MIPS_XLEN      32
`define MIPS_REG_AW    5
`define MIPS_RESET_PC  32'hbfc0_0000

// primary opcodes
`define OP_SPECIAL     6'h00
`define OP_J           6'h02
`define OP_BEQ         6'h04
`define OP_BNE         6'h05
`define OP_ADDIU       6'h09
`define OP_SLTI        6'h0a
`define OP_ANDI        6'h0c
`define OP_ORI         6'h0d
`define OP_XORI        6'h0e
`define OP_LUI         6'h0f
`define OP_LW          6'h23
`define OP_SW          6'h2b

// funct field of special
`define FN_ADDU        6'h21
`define FN_SUBU        6'h23
`define FN_AND         6'h24
`define FN_OR          6'h25
`define FN_XOR         6'h26
`define FN_NOR         6'h27
`define FN_SLT         6'h2a
`define FN_SLTU        6'h2b

`endif
